// ==== verilog/game_pkg.sv ====
package game_pkg;

    // game modes in a 3-bit encoding
    typedef enum logic [2:0] {
        MENU_MODE    = 3'b000,
        GAME_MODE    = 3'b001,
        VICTORY_MODE = 3'b010,
        GAME_OVER    = 3'b011,
        MULTI_WAIT   = 3'b100
    } mode_t;

    localparam int COORD_W = 12;  // cursor and target coordinates

    // top-left corners of the on-screen buttons
    localparam int PLAY_BOX_X  = 432;
    localparam int PLAY_BOX_Y  = 400;
    localparam int MULTI_BOX_X = 432;
    localparam int MULTI_BOX_Y = 540;
    localparam int MENU_BOX_X  = 432;
    localparam int MENU_BOX_Y  = 520;

    localparam int BOX_W = 128;
    localparam int BOX_H = 80;

    // the clickable area is a little wider on the left and top than the drawn box
    localparam int BOX_LEFT_MARGIN = 10;
    localparam int BOX_RIGHT_TRIM  = 5;
    localparam int BOX_TOP_MARGIN  = 10;

    localparam int TARGET_W = 64;
    localparam int TARGET_H = 64;
    localparam int TARGET_N = 4;                  // positions the target steps through
    localparam int IDX_W    = $clog2(TARGET_N);

    localparam logic [COORD_W-1:0] TARGET_X [TARGET_N] = '{
        12'd100, 12'd800, 12'd150, 12'd820
    };
    localparam logic [COORD_W-1:0] TARGET_Y [TARGET_N] = '{
        12'd100, 12'd120, 12'd600, 12'd650
    };

    // a round ends on whichever limit is reached first
    localparam int WIN_HITS   = 3;
    localparam int MAX_MISSES = 3;
    localparam int CNT_W      = 2;

endpackage

// ==== verilog/button_hit.sv ====
`timescale 1ns/10ps

module button_hit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [game_pkg::COORD_W-1:0] xpos,
    input  logic [game_pkg::COORD_W-1:0] ypos,
    input  logic                         mouse_left,
    output logic                         click,
    output logic                         over_play,
    output logic                         over_multi,
    output logic                         over_menu,
    output logic [game_pkg::COORD_W-1:0] cursor_x,
    output logic [game_pkg::COORD_W-1:0] cursor_y
);
    import game_pkg::*;

    logic mouse_left_q;  // button level seen at the previous edge
    logic play_hit;
    logic multi_hit;
    logic menu_hit;

    // true when the point lies in the clickable area of the button at (bx, by)
    function automatic logic in_box(input int px, input int py, input int bx, input int by);
        logic in_x;
        logic in_y;
        in_x = (px >= bx - BOX_LEFT_MARGIN) && (px <= bx + BOX_W - BOX_RIGHT_TRIM);
        in_y = (py >= by - BOX_TOP_MARGIN) && (py <= by + BOX_H);
        return in_x && in_y;
    endfunction

    assign play_hit  = in_box(int'(xpos), int'(ypos), PLAY_BOX_X, PLAY_BOX_Y);
    assign multi_hit = in_box(int'(xpos), int'(ypos), MULTI_BOX_X, MULTI_BOX_Y);
    assign menu_hit  = in_box(int'(xpos), int'(ypos), MENU_BOX_X, MENU_BOX_Y);

    always_ff @(posedge clk) begin
        cursor_x <= xpos;
        cursor_y <= ypos;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mouse_left_q <= 1'b0;
            click        <= 1'b0;
            over_play    <= 1'b0;
            over_multi   <= 1'b0;
            over_menu    <= 1'b0;
        end else begin
            mouse_left_q <= mouse_left;
            click        <= mouse_left && !mouse_left_q;  // one pulse per press
            over_play    <= play_hit;
            over_multi   <= multi_hit;
            over_menu    <= menu_hit;
        end
    end

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/10ps

module control_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            click,
    input  logic            over_play,
    input  logic            over_multi,
    input  logic            over_menu,
    input  logic            victory,
    input  logic            game_over,
    input  logic            opponent_ready,
    output game_pkg::mode_t state,
    output logic            play_selected,
    output logic            mouse_mode,
    output logic            display_buttons_m_and_s,
    output logic            player_ready,
    output logic            display_menu_button,
    output logic            multiplayer
);
    import game_pkg::*;

    mode_t state_nxt;
    logic  multi_choice;  // remembers that the game was entered through the multi button
    logic  multi_choice_nxt;
    logic  play_selected_nxt;
    logic  mouse_mode_nxt;
    logic  buttons_nxt;
    logic  player_ready_nxt;
    logic  menu_button_nxt;
    logic  multiplayer_nxt;

    always_comb begin
        state_nxt        = state;
        multi_choice_nxt = multi_choice;

        case (state)
            MENU_MODE, VICTORY_MODE, GAME_OVER: begin
                if (click) begin
                    if (over_play) begin
                        state_nxt        = GAME_MODE;
                        multi_choice_nxt = 1'b0;
                    end else if (over_multi) begin
                        state_nxt        = MULTI_WAIT;
                        multi_choice_nxt = 1'b1;
                    end else if (state != MENU_MODE) begin
                        state_nxt = MENU_MODE;  // a click anywhere leaves the result screen
                    end
                end
            end

            GAME_MODE: begin
                if (victory) begin
                    state_nxt = VICTORY_MODE;
                end else if (game_over) begin
                    state_nxt = GAME_OVER;
                end
            end

            // wait here until the second player reports ready
            MULTI_WAIT: begin
                if (opponent_ready) begin
                    state_nxt = GAME_MODE;
                end else if (click && over_menu) begin
                    state_nxt = MENU_MODE;
                end
            end

            default: begin
                state_nxt = MENU_MODE;
            end
        endcase
    end

    // outputs are decoded from the next state so they change together with it
    always_comb begin
        play_selected_nxt = 1'b0;
        mouse_mode_nxt    = 1'b0;
        buttons_nxt       = 1'b0;
        player_ready_nxt  = 1'b0;
        menu_button_nxt   = 1'b0;
        multiplayer_nxt   = 1'b0;

        case (state_nxt)
            GAME_MODE: begin
                play_selected_nxt = 1'b1;
                mouse_mode_nxt    = 1'b1;
                multiplayer_nxt   = multi_choice_nxt;
            end

            MULTI_WAIT: begin
                multiplayer_nxt  = 1'b1;
                player_ready_nxt = 1'b1;
                menu_button_nxt  = 1'b1;
            end

            default: begin
                buttons_nxt = 1'b1;  // menu, victory and game over all show the buttons
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                   <= MENU_MODE;
            multi_choice            <= 1'b0;
            play_selected           <= 1'b0;
            mouse_mode              <= 1'b0;
            display_buttons_m_and_s <= 1'b0;
            player_ready            <= 1'b0;
            display_menu_button     <= 1'b0;
            multiplayer             <= 1'b0;
        end else begin
            state                   <= state_nxt;
            multi_choice            <= multi_choice_nxt;
            play_selected           <= play_selected_nxt;
            mouse_mode              <= mouse_mode_nxt;
            display_buttons_m_and_s <= buttons_nxt;
            player_ready            <= player_ready_nxt;
            display_menu_button     <= menu_button_nxt;
            multiplayer             <= multiplayer_nxt;
        end
    end

endmodule

// ==== verilog/target_round.sv ====
`timescale 1ns/10ps

module target_round (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         play_selected,
    input  logic                         click,
    input  logic [game_pkg::COORD_W-1:0] cursor_x,
    input  logic [game_pkg::COORD_W-1:0] cursor_y,
    output logic [game_pkg::COORD_W-1:0] target_x,
    output logic [game_pkg::COORD_W-1:0] target_y,
    output logic [game_pkg::CNT_W-1:0]   hits,
    output logic [game_pkg::CNT_W-1:0]   misses,
    output logic                         victory,
    output logic                         game_over
);
    import game_pkg::*;

    logic [IDX_W-1:0] idx;  // current entry of the target position table
    logic             on_target;

    assign target_x = TARGET_X[idx];
    assign target_y = TARGET_Y[idx];

    // the box edges count as inside
    assign on_target = (cursor_x >= target_x) && (cursor_x <= target_x + TARGET_W) &&
                       (cursor_y >= target_y) && (cursor_y <= target_y + TARGET_H);

    always_ff @(posedge clk) begin
        if (rst) begin
            idx       <= '0;
            hits      <= '0;
            misses    <= '0;
            victory   <= 1'b0;
            game_over <= 1'b0;
        end else begin
            victory   <= 1'b0;
            game_over <= 1'b0;

            if (!play_selected) begin
                // no round running outside game mode
                idx    <= '0;
                hits   <= '0;
                misses <= '0;
            end else if (click) begin
                if (on_target) begin
                    if (hits == CNT_W'(WIN_HITS - 1)) begin
                        victory <= 1'b1;
                        idx     <= '0;
                        hits    <= '0;
                        misses  <= '0;
                    end else begin
                        hits <= hits + 1'b1;
                        idx  <= idx + 1'b1;  // wraps after the last position
                    end
                end else begin
                    if (misses == CNT_W'(MAX_MISSES - 1)) begin
                        game_over <= 1'b1;
                        idx       <= '0;
                        hits      <= '0;
                        misses    <= '0;
                    end else begin
                        misses <= misses + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== verilog/menu_top.sv ====
`timescale 1ns/10ps

module menu_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [game_pkg::COORD_W-1:0] xpos,
    input  logic [game_pkg::COORD_W-1:0] ypos,
    input  logic                         mouse_left,
    input  logic                         opponent_ready,
    output game_pkg::mode_t              state,
    output logic                         play_selected,
    output logic                         mouse_mode,
    output logic                         display_buttons_m_and_s,
    output logic                         player_ready,
    output logic                         display_menu_button,
    output logic                         multiplayer,
    output logic [game_pkg::COORD_W-1:0] target_x,
    output logic [game_pkg::COORD_W-1:0] target_y,
    output logic [game_pkg::CNT_W-1:0]   hits,
    output logic [game_pkg::CNT_W-1:0]   misses
);
    import game_pkg::*;

    logic               click;
    logic               over_play;
    logic               over_multi;
    logic               over_menu;
    logic [COORD_W-1:0] cursor_x;
    logic [COORD_W-1:0] cursor_y;
    logic               victory;
    logic               game_over;

    button_hit hit_i (
        .clk        (clk),
        .rst        (rst),
        .xpos       (xpos),
        .ypos       (ypos),
        .mouse_left (mouse_left),
        .click      (click),
        .over_play  (over_play),
        .over_multi (over_multi),
        .over_menu  (over_menu),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y)
    );

    control_unit ctrl_i (
        .clk                     (clk),
        .rst                     (rst),
        .click                   (click),
        .over_play               (over_play),
        .over_multi              (over_multi),
        .over_menu               (over_menu),
        .victory                 (victory),
        .game_over               (game_over),
        .opponent_ready          (opponent_ready),
        .state                   (state),
        .play_selected           (play_selected),
        .mouse_mode              (mouse_mode),
        .display_buttons_m_and_s (display_buttons_m_and_s),
        .player_ready            (player_ready),
        .display_menu_button     (display_menu_button),
        .multiplayer             (multiplayer)
    );

    target_round round_i (
        .clk           (clk),
        .rst           (rst),
        .play_selected (play_selected),
        .click         (click),
        .cursor_x      (cursor_x),
        .cursor_y      (cursor_y),
        .target_x      (target_x),
        .target_y      (target_y),
        .hits          (hits),
        .misses        (misses),
        .victory       (victory),
        .game_over     (game_over)
    );

endmodule

// ==== dv/tb_menu_top.sv ====
`timescale 1ns/10ps

module tb_menu_top;
    import game_pkg::*;

    logic               clk = 1'b0;
    logic               rst;
    logic [COORD_W-1:0] xpos;
    logic [COORD_W-1:0] ypos;
    logic               mouse_left;
    logic               opponent_ready;
    mode_t              state;
    logic               play_selected;
    logic               mouse_mode;
    logic               display_buttons_m_and_s;
    logic               player_ready;
    logic               display_menu_button;
    logic               multiplayer;
    logic [COORD_W-1:0] target_x;
    logic [COORD_W-1:0] target_y;
    logic [CNT_W-1:0]   hits;
    logic [CNT_W-1:0]   misses;

    // reference model of the game flow
    mode_t       m_state;
    bit          m_choice;
    int          m_hits;
    int          m_misses;
    int          m_idx;
    int unsigned rand_state = 32'd32825;

    // stimulus table with one entry per row in each queue
    int    row_x[$];
    int    row_y[$];
    int    row_hold[$];   // cycles that mouse_left stays high or 0 for no press
    bit    row_opp[$];
    mode_t row_state[$];
    bit    row_multi[$];
    int    row_hits[$];
    int    row_misses[$];

    always #4 clk = ~clk;

    menu_top dut_i (
        .clk                     (clk),
        .rst                     (rst),
        .xpos                    (xpos),
        .ypos                    (ypos),
        .mouse_left              (mouse_left),
        .opponent_ready          (opponent_ready),
        .state                   (state),
        .play_selected           (play_selected),
        .mouse_mode              (mouse_mode),
        .display_buttons_m_and_s (display_buttons_m_and_s),
        .player_ready            (player_ready),
        .display_menu_button     (display_menu_button),
        .multiplayer             (multiplayer),
        .target_x                (target_x),
        .target_y                (target_y),
        .hits                    (hits),
        .misses                  (misses)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // the clickable area of a button is wider on the left and top than the drawn box
    function automatic bit on_button(input int px, input int py, input int bx, input int by);
        return (px >= bx - BOX_LEFT_MARGIN) && (px <= bx + BOX_W - BOX_RIGHT_TRIM) &&
               (py >= by - BOX_TOP_MARGIN) && (py <= by + BOX_H);
    endfunction

    function automatic bit on_target(input int px, input int py, input int i);
        int tx;
        int ty;
        tx = int'(TARGET_X[i]);
        ty = int'(TARGET_Y[i]);
        return (px >= tx) && (px <= tx + TARGET_W) && (py >= ty) && (py <= ty + TARGET_H);
    endfunction

    function automatic bit expected_multi();
        return (m_state == MULTI_WAIT) || (m_state == GAME_MODE && m_choice);
    endfunction

    task automatic wait_cycles(input int n);
        int count;
        count = 0;
        while (count < n) begin
            @(posedge clk);
            count++;
        end
    endtask

    // random point clear of every target position and every button
    task automatic pick_miss(output int px, output int py);
        int tries;
        bit clear;
        tries = 0;
        clear = 1'b0;
        while (!clear) begin
            if (tries == 1000) fail_now("random generator found no point off the targets");
            px = int'(next_rand() >> 16) % 1024;
            py = int'(next_rand() >> 16) % 768;
            clear = !on_button(px, py, PLAY_BOX_X, PLAY_BOX_Y) &&
                    !on_button(px, py, MULTI_BOX_X, MULTI_BOX_Y) &&
                    !on_button(px, py, MENU_BOX_X, MENU_BOX_Y);
            for (int i = 0; i < TARGET_N; i++) begin
                if (on_target(px, py, i)) clear = 1'b0;
            end
            tries++;
        end
    endtask

    task automatic add_row(input int x, input int y, input int hold, input bit opp,
                           input mode_t st, input bit mp, input int h, input int m);
        row_x.push_back(x);
        row_y.push_back(y);
        row_hold.push_back(hold);
        row_opp.push_back(opp);
        row_state.push_back(st);
        row_multi.push_back(mp);
        row_hits.push_back(h);
        row_misses.push_back(m);
    endtask

    task automatic build_table();
        int mx;
        int my;
        // single player win where the second hit is a long press on the far target edge
        add_row(480, 430, 1, 0, GAME_MODE, 0, 0, 0);
        add_row(110, 110, 1, 0, GAME_MODE, 0, 1, 0);
        add_row(864, 184, 5, 0, GAME_MODE, 0, 2, 0);
        add_row(170, 620, 1, 0, VICTORY_MODE, 0, 0, 0);
        // three misses lose the round
        add_row(480, 430, 1, 0, GAME_MODE, 0, 0, 0);
        pick_miss(mx, my);
        add_row(mx, my, 1, 0, GAME_MODE, 0, 0, 1);
        pick_miss(mx, my);
        add_row(mx, my, 1, 0, GAME_MODE, 0, 0, 2);
        pick_miss(mx, my);
        add_row(mx, my, 1, 0, GAME_OVER, 0, 0, 0);
        pick_miss(mx, my);
        add_row(mx, my, 1, 0, MENU_MODE, 0, 0, 0);
        // multiplayer wait and back to the menu
        add_row(480, 610, 1, 0, MULTI_WAIT, 1, 0, 0);
        add_row(480, 515, 1, 0, MENU_MODE, 0, 0, 0);
        // multiplayer game once the opponent is ready
        add_row(480, 610, 1, 0, MULTI_WAIT, 1, 0, 0);
        pick_miss(mx, my);
        add_row(mx, my, 0, 1, GAME_MODE, 1, 0, 0);
        add_row(100, 100, 1, 0, GAME_MODE, 1, 1, 0);
        add_row(830, 130, 1, 0, GAME_MODE, 1, 2, 0);
        add_row(200, 650, 1, 0, VICTORY_MODE, 0, 0, 0);
        add_row(480, 430, 1, 0, GAME_MODE, 0, 0, 0);
    endtask

    task automatic model_step(input int px, input int py, input int hold, input bit opp);
        if (opp && m_state == MULTI_WAIT) m_state = GAME_MODE;
        if (hold > 0) begin
            case (m_state)
                MENU_MODE, VICTORY_MODE, GAME_OVER: begin
                    if (on_button(px, py, PLAY_BOX_X, PLAY_BOX_Y)) begin
                        m_state  = GAME_MODE;
                        m_choice = 1'b0;
                    end else if (on_button(px, py, MULTI_BOX_X, MULTI_BOX_Y)) begin
                        m_state  = MULTI_WAIT;
                        m_choice = 1'b1;
                    end else if (m_state != MENU_MODE) begin
                        m_state = MENU_MODE;
                    end
                end
                GAME_MODE: begin
                    if (on_target(px, py, m_idx)) begin
                        m_hits++;
                        m_idx = (m_idx + 1) % TARGET_N;
                        if (m_hits == WIN_HITS) m_state = VICTORY_MODE;
                    end else begin
                        m_misses++;
                        if (m_misses == MAX_MISSES) m_state = GAME_OVER;
                    end
                end
                MULTI_WAIT: begin
                    if (on_button(px, py, MENU_BOX_X, MENU_BOX_Y)) m_state = MENU_MODE;
                end
                default: ;
            endcase
        end
        if (m_state != GAME_MODE) begin  // the round is cleared outside game mode
            m_hits   = 0;
            m_misses = 0;
            m_idx    = 0;
        end
    endtask

    task automatic check_outputs(input string label);
        bit       in_game;
        bit       in_wait;
        bit [5:0] got;
        bit [5:0] exp;
        in_game = (m_state == GAME_MODE);
        in_wait = (m_state == MULTI_WAIT);
        got = {play_selected, mouse_mode, display_buttons_m_and_s,
               player_ready, display_menu_button, multiplayer};
        exp = {in_game, in_game, !(in_game || in_wait), in_wait, in_wait, expected_multi()};
        assert (state == m_state)
            else fail_now($sformatf("** Error at %0t: %s state is %s, expected %s",
                $time, label, state.name(), m_state.name()));
        assert (got == exp)
            else fail_now($sformatf("** Error at %0t: %s control levels %b, expected %b",
                $time, label, got, exp));
        assert (int'(hits) == m_hits && int'(misses) == m_misses)
            else fail_now($sformatf("** Error at %0t: %s hits/misses %0d/%0d, expected %0d/%0d",
                $time, label, hits, misses, m_hits, m_misses));
        assert (target_x == TARGET_X[m_idx] && target_y == TARGET_Y[m_idx])
            else fail_now($sformatf("** Error at %0t: %s target at (%0d,%0d), expected entry %0d",
                $time, label, target_x, target_y, m_idx));
    endtask

    task automatic apply_row(input int i);
        int held;
        @(posedge clk);
        xpos           <= COORD_W'(row_x[i]);
        ypos           <= COORD_W'(row_y[i]);
        opponent_ready <= row_opp[i];
        mouse_left     <= (row_hold[i] > 0);
        held = 1;
        while (held < row_hold[i]) begin
            @(posedge clk);
            held++;
        end
        @(posedge clk);
        mouse_left <= 1'b0;
        wait_cycles(4);
        @(negedge clk);  // outputs are settled away from the rising edge
    endtask

    initial begin
        #100000;
        fail_now("simulation ran past its time limit");
    end

    initial begin
        rst            <= 1'b1;
        xpos           <= '0;
        ypos           <= '0;
        mouse_left     <= 1'b0;
        opponent_ready <= 1'b0;
        m_state  = MENU_MODE;
        m_choice = 1'b0;
        m_hits   = 0;
        m_misses = 0;
        m_idx    = 0;
        build_table();

        wait_cycles(16);
        rst <= 1'b0;
        wait_cycles(2);
        @(negedge clk);
        check_outputs("after reset");

        for (int i = 0; i < row_x.size(); i++) begin
            apply_row(i);
            model_step(row_x[i], row_y[i], row_hold[i], row_opp[i]);
            assert (row_state[i] == m_state && row_multi[i] == expected_multi() &&
                    row_hits[i] == m_hits && row_misses[i] == m_misses)
                else fail_now($sformatf("table row %0d disagrees with the model", i));
            check_outputs($sformatf("row %0d", i));
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/game_pkg.sv
verilog/button_hit.sv
verilog/control_unit.sv
verilog/target_round.sv
verilog/menu_top.sv
dv/tb_menu_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the menu_top testbench with Verilator.
# The simulator exits non-zero when the testbench stops on a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_menu_top \
    -Mdir obj_dir \
    -f project.f

./obj_dir/Vtb_menu_top
